// File: rtl/mips_pkg.sv
package mips_pkg;

    ////////////////////////////////////////////////////////////
    // Primary opcodes, instr[31:26]
    ////////////////////////////////////////////////////////////
    localparam logic [5:0] OP_RTYPE = 6'h00;  // Uses func field
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_ANDI  = 6'h0c;  // Zero-extended imm
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_XORI  = 6'h0e;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    // R-type function codes, instr[5:0]
    localparam logic [5:0] FN_SLL = 6'h00;
    localparam logic [5:0] FN_SRL = 6'h02;
    localparam logic [5:0] FN_SRA = 6'h03;
    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR  = 6'h25;
    localparam logic [5:0] FN_XOR = 6'h26;
    localparam logic [5:0] FN_SLT = 6'h2a;

    ////////////////////////////////////////////////////////////
    // ALU operation select
    ////////////////////////////////////////////////////////////
    localparam logic [3:0] ALU_ADD = 4'd0;
    localparam logic [3:0] ALU_SUB = 4'd1;
    localparam logic [3:0] ALU_AND = 4'd2;
    localparam logic [3:0] ALU_OR  = 4'd3;
    localparam logic [3:0] ALU_XOR = 4'd4;
    localparam logic [3:0] ALU_SLT = 4'd5;  // Signed compare
    localparam logic [3:0] ALU_SLL = 4'd6;
    localparam logic [3:0] ALU_SRL = 4'd7;
    localparam logic [3:0] ALU_SRA = 4'd8;
    localparam logic [3:0] ALU_LUI = 4'd9;  // b into upper half

    // Next-PC source
    localparam logic [1:0] PC_SEQ    = 2'd0;
    localparam logic [1:0] PC_BRANCH = 2'd1;
    localparam logic [1:0] PC_JUMP   = 2'd2;

    // Data memory geometry
    localparam int DMEM_DEPTH = 64;  // Words
    localparam int DMEM_AW    = 6;   // Word address bits

    ////////////////////////////////////////////////////////////
    // Instruction word, three views of the same 32 bits
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] func;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } i_fields_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [25:0] index26;
    } j_fields_t;

    typedef union packed {
        r_fields_t r;
        i_fields_t i;
        j_fields_t j;
    } instr_t;

endpackage

// File: rtl/control_unit.sv
`timescale 1ns/10ps

module control_unit (
    input  logic [5:0] op,
    input  logic [5:0] func,
    input  logic       zero,      // From ALU compare
    output logic [3:0] aluc,
    output logic       wrf,       // Register write
    output logic       sext_i,    // Sign-extend imm16
    output logic       sext_s,    // Sign-extend shamt
    output logic       shift,     // ALU A from shamt
    output logic       regwa,     // 1 = write rt, 0 = write rd
    output logic       immc,      // ALU B from imm32
    output logic       wdmem,     // Memory write
    output logic       wdc,       // Writeback from memory
    output logic [1:0] pcsource
);

    always_comb begin
        // Everything inactive unless decoded below
        aluc     = mips_pkg::ALU_ADD;
        wrf      = 1'b0;
        sext_i   = 1'b0;
        sext_s   = 1'b0;  // shamt is unsigned
        shift    = 1'b0;
        regwa    = 1'b0;
        immc     = 1'b0;
        wdmem    = 1'b0;
        wdc      = 1'b0;
        pcsource = mips_pkg::PC_SEQ;

        case (op)
            mips_pkg::OP_RTYPE: begin
                wrf = 1'b1;  // Cleared again for unknown func
                case (func)
                    mips_pkg::FN_ADD: aluc = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUB: aluc = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND: aluc = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:  aluc = mips_pkg::ALU_OR;
                    mips_pkg::FN_XOR: aluc = mips_pkg::ALU_XOR;
                    mips_pkg::FN_SLT: aluc = mips_pkg::ALU_SLT;
                    mips_pkg::FN_SLL: begin
                        aluc  = mips_pkg::ALU_SLL;
                        shift = 1'b1;
                    end
                    mips_pkg::FN_SRL: begin
                        aluc  = mips_pkg::ALU_SRL;
                        shift = 1'b1;
                    end
                    mips_pkg::FN_SRA: begin
                        aluc  = mips_pkg::ALU_SRA;
                        shift = 1'b1;
                    end
                    default: wrf = 1'b0;  // Unsupported func acts as nop
                endcase
            end

            // Immediate ALU group, result to rt
            mips_pkg::OP_ADDI: begin
                {wrf, regwa, immc, sext_i} = 4'b1111;
                aluc = mips_pkg::ALU_ADD;
            end
            mips_pkg::OP_ANDI: begin
                {wrf, regwa, immc} = 3'b111;
                aluc = mips_pkg::ALU_AND;
            end
            mips_pkg::OP_ORI: begin
                {wrf, regwa, immc} = 3'b111;
                aluc = mips_pkg::ALU_OR;
            end
            mips_pkg::OP_XORI: begin
                {wrf, regwa, immc} = 3'b111;
                aluc = mips_pkg::ALU_XOR;
            end
            mips_pkg::OP_LUI: begin
                {wrf, regwa, immc} = 3'b111;
                aluc = mips_pkg::ALU_LUI;
            end

            mips_pkg::OP_LW: begin
                {wrf, regwa, immc, sext_i, wdc} = 5'b11111;
            end
            mips_pkg::OP_SW: begin
                {immc, sext_i, wdmem} = 3'b111;  // Address = rs + imm
            end

            // Compare rs against rt through subtract
            mips_pkg::OP_BEQ: begin
                aluc     = mips_pkg::ALU_SUB;
                pcsource = zero ? mips_pkg::PC_BRANCH : mips_pkg::PC_SEQ;
            end
            mips_pkg::OP_BNE: begin
                aluc     = mips_pkg::ALU_SUB;
                pcsource = zero ? mips_pkg::PC_SEQ : mips_pkg::PC_BRANCH;
            end
            mips_pkg::OP_J: pcsource = mips_pkg::PC_JUMP;

            default: ;  // Unknown opcode, nop
        endcase
    end

endmodule

// File: rtl/reg_file.sv
`timescale 1ns/10ps

module reg_file (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        we,
    input  logic [4:0]  ra1,
    input  logic [4:0]  ra2,
    input  logic [4:0]  wa,
    input  logic [31:0] wd,
    output logic [31:0] rd1,
    output logic [31:0] rd2
);

    logic [31:0] regs [32];

    // Write port, r0 never written
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (we && (wa != 5'd0)) begin
            regs[wa] <= wd;
        end
    end

    ////////////////////////////////////////////////////////////
    // Asynchronous read ports
    ////////////////////////////////////////////////////////////
    assign rd1 = (ra1 == 5'd0) ? 32'd0 : regs[ra1];  // r0 hardwired
    assign rd2 = (ra2 == 5'd0) ? 32'd0 : regs[ra2];

endmodule

// File: rtl/decode_stage.sv
`timescale 1ns/10ps

module decode_stage (
    input  logic             clk,
    input  logic             rst_n,
    input  mips_pkg::instr_t instr,     // Word from fetch
    input  logic [31:0]      wd,        // Writeback data
    input  logic             rf_wena,   // Writeback enable
    input  logic [4:0]       wa,        // Writeback address
    input  logic             zero,
    input  logic             overflow,
    output logic [31:0]      rd1,       // Source operand rs
    output logic [31:0]      rd2,       // Source operand rt
    output logic [31:0]      shamt32,
    output logic [31:0]      imm32,
    output logic [4:0]       wa_d,      // Destination register
    output logic [17:0]      imm18,     // Branch byte offset
    output logic [27:0]      index28,   // Jump byte target
    output logic [3:0]       aluc,
    output logic             wrf,
    output logic             shift,
    output logic             immc,
    output logic             wdmem,
    output logic             wdc,
    output logic [1:0]       pcsource
);

    logic sext_i;
    logic sext_s;
    logic regwa;
    logic rf_w;

    // Overflowing add/sub/addi drops its write
    assign rf_w = rf_wena && !overflow;

    reg_file i_reg_file (
        .clk   (clk),
        .rst_n (rst_n),
        .we    (rf_w),
        .ra1   (instr.r.rs),
        .ra2   (instr.r.rt),
        .wa    (wa),
        .wd    (wd),
        .rd1   (rd1),
        .rd2   (rd2)
    );

    control_unit i_control_unit (
        .op       (instr.r.op),
        .func     (instr.r.func),
        .zero     (zero),
        .aluc     (aluc),
        .wrf      (wrf),
        .sext_i   (sext_i),
        .sext_s   (sext_s),
        .shift    (shift),
        .regwa    (regwa),
        .immc     (immc),
        .wdmem    (wdmem),
        .wdc      (wdc),
        .pcsource (pcsource)
    );

    ////////////////////////////////////////////////////////////
    // Field extension and offsets
    ////////////////////////////////////////////////////////////
    assign imm32   = {{16{sext_i & instr.i.imm16[15]}}, instr.i.imm16};
    assign shamt32 = {{27{sext_s & instr.r.shamt[4]}}, instr.r.shamt};
    assign wa_d    = regwa ? instr.r.rt : instr.r.rd;  // I-type writes rt
    assign imm18   = {instr.i.imm16, 2'b00};            // Words to bytes
    assign index28 = {instr.j.index26, 2'b00};

endmodule

// File: rtl/alu.sv
`timescale 1ns/10ps

module alu (
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  logic [3:0]  aluc,
    output logic [31:0] result,
    output logic        zero,
    output logic        overflow   // Signed, add/sub only
);

    logic [31:0] sum;
    logic [31:0] diff;
    logic        ovf_add;
    logic        ovf_sub;

    assign sum  = a + b;
    assign diff = a - b;

    // Same-sign inputs, flipped result sign
    assign ovf_add = (a[31] == b[31]) && (sum[31] != a[31]);
    // Opposite-sign inputs, result sign differs from a
    assign ovf_sub = (a[31] != b[31]) && (diff[31] != a[31]);

    ////////////////////////////////////////////////////////////
    // Operation select
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (aluc)
            mips_pkg::ALU_ADD: result = sum;
            mips_pkg::ALU_SUB: result = diff;
            mips_pkg::ALU_AND: result = a & b;
            mips_pkg::ALU_OR:  result = a | b;
            mips_pkg::ALU_XOR: result = a ^ b;
            mips_pkg::ALU_SLT: result = {31'd0, $signed(a) < $signed(b)};
            mips_pkg::ALU_SLL: result = b << a[4:0];             // a holds shamt
            mips_pkg::ALU_SRL: result = b >> a[4:0];
            mips_pkg::ALU_SRA: result = $signed(b) >>> a[4:0];   // Sign fill
            mips_pkg::ALU_LUI: result = {b[15:0], 16'd0};
            default:           result = 32'd0;
        endcase
    end

    always_comb begin
        case (aluc)
            mips_pkg::ALU_ADD: overflow = ovf_add;
            mips_pkg::ALU_SUB: overflow = ovf_sub;
            default:           overflow = 1'b0;
        endcase
    end

    assign zero = (result == 32'd0);  // beq/bne compare

endmodule

// File: rtl/fetch_stage.sv
`timescale 1ns/10ps

module fetch_stage (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [1:0]  pcsource,
    input  logic [17:0] imm18,     // Branch byte offset
    input  logic [27:0] index28,   // Jump byte target
    output logic [31:0] pc
);

    logic [31:0] pc_plus4;
    logic [31:0] br_target;
    logic [31:0] jmp_target;
    logic [31:0] pc_next;

    assign pc_plus4   = pc + 32'd4;
    assign br_target  = pc_plus4 + {{14{imm18[17]}}, imm18};  // Relative to delay slot addr
    assign jmp_target = {pc_plus4[31:28], index28};          // Same 256 MB region

    ////////////////////////////////////////////////////////////
    // Next-PC mux
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (pcsource)
            mips_pkg::PC_BRANCH: pc_next = br_target;
            mips_pkg::PC_JUMP:   pc_next = jmp_target;
            default:             pc_next = pc_plus4;
        endcase
    end

    // One instruction per clock
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= 32'd0;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

// File: rtl/data_mem.sv
`timescale 1ns/10ps

module data_mem (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        we,
    input  logic [mips_pkg::DMEM_AW-1:0] addr,   // Word address
    input  logic [31:0]                 wdata,
    output logic [31:0]                 rdata
);

    logic [31:0] mem [mips_pkg::DMEM_DEPTH];

    // Store commits on the clock edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < mips_pkg::DMEM_DEPTH; i++) begin
                mem[i] <= 32'd0;
            end
        end else if (we) begin
            mem[addr] <= wdata;
        end
    end

    assign rdata = mem[addr];  // Load sees data same cycle

endmodule

// File: rtl/mips_core.sv
`timescale 1ns/10ps

module mips_core (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] instr,     // From instruction memory
    output logic [31:0] pc,
    output logic        wb_en,     // Commit strobe
    output logic [4:0]  wb_addr,
    output logic [31:0] wb_data
);

    logic [31:0] rd1;
    logic [31:0] rd2;
    logic [31:0] imm32;
    logic [31:0] shamt32;
    logic [4:0]  wa_d;
    logic [17:0] imm18;
    logic [27:0] index28;
    logic [3:0]  aluc;
    logic        wrf;
    logic        shift;
    logic        immc;
    logic        wdmem;
    logic        wdc;
    logic [1:0]  pcsource;
    logic [31:0] alu_a;
    logic [31:0] alu_b;
    logic [31:0] alu_res;
    logic        zero;
    logic        overflow;
    logic [31:0] mem_rdata;
    logic [31:0] wd;

    fetch_stage i_fetch_stage (
        .clk      (clk),
        .rst_n    (rst_n),
        .pcsource (pcsource),
        .imm18    (imm18),
        .index28  (index28),
        .pc       (pc)
    );

    decode_stage i_decode_stage (
        .clk      (clk),
        .rst_n    (rst_n),
        .instr    (instr),
        .wd       (wd),
        .rf_wena  (wrf),
        .wa       (wa_d),
        .zero     (zero),
        .overflow (overflow),
        .rd1      (rd1),
        .rd2      (rd2),
        .shamt32  (shamt32),
        .imm32    (imm32),
        .wa_d     (wa_d),
        .imm18    (imm18),
        .index28  (index28),
        .aluc     (aluc),
        .wrf      (wrf),
        .shift    (shift),
        .immc     (immc),
        .wdmem    (wdmem),
        .wdc      (wdc),
        .pcsource (pcsource)
    );

    ////////////////////////////////////////////////////////////
    // Execute and memory
    ////////////////////////////////////////////////////////////
    assign alu_a = shift ? shamt32 : rd1;  // Shifts take shamt as A
    assign alu_b = immc ? imm32 : rd2;

    alu i_alu (
        .a        (alu_a),
        .b        (alu_b),
        .aluc     (aluc),
        .result   (alu_res),
        .zero     (zero),
        .overflow (overflow)
    );

    data_mem i_data_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .we    (wdmem),
        .addr  (alu_res[mips_pkg::DMEM_AW+1:2]),  // Byte to word address
        .wdata (rd2),
        .rdata (mem_rdata)
    );

    // Writeback select and commit view
    assign wd      = wdc ? mem_rdata : alu_res;
    assign wb_en   = rst_n && wrf && !overflow;  // No commit in reset or on overflow
    assign wb_addr = wa_d;
    assign wb_data = wd;

endmodule

// File: verification/mips_core_tb.sv
`timescale 1ns/10ps

module mips_core_tb;

    logic        clk;
    logic        rst_n;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        wb_en;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;

    logic [31:0] image [1024];  // Words 0-255 program, 256 up trace
    int          n_rec;         // Trace records before end marker
    int          n_checks;
    int          n_errors;
    int          cycles = 0;
    int          limit  = 0;

    mips_core i_mips_core (
        .clk     (clk),
        .rst_n   (rst_n),
        .instr   (instr),
        .pc      (pc),
        .wb_en   (wb_en),
        .wb_addr (wb_addr),
        .wb_data (wb_data)
    );

    // Instruction memory, word answered in the same cycle
    assign instr = image[{2'b00, pc[9:2]}];

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;  // 40 ns period
        end
    end

    ////////////////////////////////////////////////////////////
    // Compare helpers
    ////////////////////////////////////////////////////////////
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("FAIL %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // Record r is pc, write flag, write address, write data
    task automatic verify_record(input int r);
        logic [9:0] base;
        base = 10'(256 + 4 * r);
        check_value($sformatf("trace %0d pc", r), image[base], pc);
        check_value($sformatf("trace %0d wb_en", r), image[base + 10'd1],
                    {31'd0, wb_en});
        if (image[base + 10'd1] != 32'd0) begin  // Address and data only on a commit
            check_value($sformatf("trace %0d wb_addr", r), image[base + 10'd2],
                        {27'd0, wb_addr});
            check_value($sformatf("trace %0d wb_data", r), image[base + 10'd3],
                        wb_data);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Watchdog
    ////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("Timeout, the program did not finish within %0d cycles", limit);
            $display("Checks %0d, errors %0d", n_checks, n_errors + 1);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        logic found;
        rst_n    = 1'b0;
        n_checks = 0;
        n_errors = 0;
        n_rec    = 0;
        found    = 1'b0;

        // Unknown opcode plus full address, runs as a nop
        for (int i = 0; i < 1024; i++) begin
            image[10'(i)] = {6'h3f, 26'(i)};
        end
        $readmemh("verification/program_input.hex", image);

        // Trace length up to the ffffffff marker
        while (!found && n_rec < 192) begin
            if (image[10'(256 + 4 * n_rec)] == 32'hffff_ffff) begin
                found = 1'b1;
            end else begin
                n_rec++;
            end
        end
        if (!found) begin
            $display("The trace in the data file has no end marker");
            n_errors++;
        end
        limit = n_rec + 3 + 20;  // Reset cycles plus margin

        // pc held at 0, no commit while in reset
        repeat (3) begin
            @(negedge clk);
            check_value("reset pc", 32'd0, pc);
            check_value("reset wb_en", 32'd0, {31'd0, wb_en});
        end
        rst_n = 1'b1;

        for (int r = 0; r < n_rec; r++) begin
            if (r > 0) begin
                @(negedge clk);
            end
            verify_record(r);  // Outputs settled half a cycle
        end

        $display("Checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: verification/program_input.hex
// Program from word 0x000, four words per line, first byte pc in the comment.
// Trace from word 0x100, columns pc, write flag, write addr, write data; ffffffff ends it.
@000
10000000 00430825 2002FFFB 34038001  // 00 beq r0 r0, or r1, addi r2 -5, ori r3
3044F0F0 38458000 3C068765 00433820  // 10 andi r4, xori r5, lui r6, add r7
00434022 00464824 00C35026 0043582A  // 20 sub r8, and r9, xor r10, slt r11
0046602A 00036900 00067202 00067A03  // 30 slt r12, sll r13, srl r14, sra r15
3C107FFF 3610FFFF 20110001 02118820  // 40 lui/ori r16 max, addi r17, add overflows
02209825 20001234 0000A025 20150040  // 50 or r19, addi r0, or r20, addi r21 base
AEA60000 AEAA0004 AEA2FFFC 8EB60000  // 60 sw x3, lw r22
8EB70004 8EB8FFFC 10430005 14420005  // 70 lw r23 r24, beq and bne not taken
12D60001 2019DEAD 14430001 2019BEEF  // 80 beq taken, skipped, bne taken, skipped
201A0003 237B0005 235AFFFF 1740FFFD  // 90 three-pass loop
08000030 20190BAD 20190BAD 20190BAD  // A0 j to C0
20190BAD 20190BAD 20190BAD 20190BAD  // B0 jumped over
0379E025 08000031                    // C0 or r28, halt
@100
00 0 00 00000000   04 1 01 00000000  // Reset state, unwritten regs read 0
08 1 02 FFFFFFFB   0C 1 03 00008001  // Sign and zero extension
10 1 04 0000F0F0   14 1 05 FFFF7FFB
18 1 06 87650000   1C 1 07 00007FFC  // lui upper half
20 1 08 FFFF7FFA   24 1 09 87650000
28 1 0A 87658001   2C 1 0B 00000001  // slt negative vs positive
30 1 0C 00000000   34 1 0D 00080010
38 1 0E 00876500   3C 1 0F FF876500  // sra fills sign
40 1 10 7FFF0000   44 1 10 7FFFFFFF
48 1 11 00000001   4C 0 00 00000000  // Overflow, no commit
50 1 13 00000001   54 1 00 00001234  // r17 unchanged
58 1 14 00000000   5C 1 15 00000040  // r0 still zero
60 0 00 00000000   64 0 00 00000000  // Stores never commit
68 0 00 00000000   6C 1 16 87650000
70 1 17 87658001   74 1 18 FFFFFFFB
78 0 00 00000000   7C 0 00 00000000  // Branches not taken
80 0 00 00000000   88 0 00 00000000  // Branches taken
90 1 1A 00000003   94 1 1B 00000005
98 1 1A 00000002   9C 0 00 00000000
94 1 1B 0000000A   98 1 1A 00000001
9C 0 00 00000000   94 1 1B 0000000F
98 1 1A 00000000   9C 0 00 00000000  // Loop exits
A0 0 00 00000000   C0 1 1C 0000000F  // Jump target, r25 never written
C4 0 00 00000000   C4 0 00 00000000  // Self jump
FFFFFFFF

// File: sim.f
rtl/mips_pkg.sv
rtl/control_unit.sv
rtl/reg_file.sv
rtl/decode_stage.sv
rtl/alu.sv
rtl/fetch_stage.sv
rtl/data_mem.sv
rtl/mips_core.sv
verification/mips_core_tb.sv

// File: Makefile
TOP = mips_core_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sim.f --top-module $(TOP)

sim:
	verilator --binary -f sim.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir
